/* include/pmp_config.svh */
/* PMP unit build configuration
   Region count, checker channels and NAPOT granule size */
`ifndef PMP_CONFIG_SVH
`define PMP_CONFIG_SVH

// Number of implemented PMP regions
`define PMP_NUM_REGIONS 4

// Number of checker channels, e.g. I-side and D-side
`define PMP_NUM_CHAN 2

// NAPOT granule exponent
// 0 = 4 byte, 1 = 8 byte, 2 = 16 byte and so on
`define PMP_GRANULARITY 0

// Lowest address bit that takes part in matching
`define PMP_GRAN_LSB (`PMP_GRANULARITY + 2)

// Index widths, never narrower than one bit
`define PMP_REGION_IDX_W (($clog2(`PMP_NUM_REGIONS) > 0) ? $clog2(`PMP_NUM_REGIONS) : 1)
`define PMP_CHAN_IDX_W (($clog2(`PMP_NUM_CHAN) > 0) ? $clog2(`PMP_NUM_CHAN) : 1)

`endif

/* hw/priv_pkg.sv */
/* Privilege levels and access types
   shared by the PMP checkers and the fault log */
`default_nettype none

package priv_pkg;

  // ----------------------------------------
  // Privilege modes
  // ----------------------------------------

  // Same encoding as mstatus.MPP, 2'b10 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // ----------------------------------------
  // Access types
  // ----------------------------------------

  // One access kind per request
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_READ  = 2'b10
  } pmp_acc_e;

endpackage

`default_nettype wire

/* hw/pmp_pkg.sv */
/* PMP configuration types
   Region cfg fields, address modes, mseccfg bits and CSR selects */
`default_nettype none

package pmp_pkg;

  // Address matching mode, same as the A field of pmpcfg
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // One region cfg byte without the two reserved bits
  // Byte layout on the CSR port: L=7, A=4:3, X=2, W=1, R=0
  typedef struct packed {
    logic      lock;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // Smepmp security bits
  // CSR port layout: RLB=2, MMWP=1, MML=0
  typedef struct packed {
    logic rlb;
    logic mmwp;
    logic mml;
  } pmp_mseccfg_t;

  // 34-bit physical address, Sv32 style
  typedef logic [33:0] pmp_addr_t;

  // Target of a CSR read or write
  typedef enum logic [1:0] {
    CSR_SEL_CFG     = 2'b00,
    CSR_SEL_ADDR    = 2'b01,
    CSR_SEL_MSECCFG = 2'b10
  } csr_sel_e;

endpackage

`default_nettype wire

/* hw/pmp_chan_if.sv */
/* PMP channel interface
   One request stream and its registered verdict */
`timescale 1ns/1ps
`default_nettype none

interface pmp_chan_if;
  import priv_pkg::*;
  import pmp_pkg::*;

  // Request side, driven from the top level ports
  logic      req_valid;
  pmp_addr_t req_addr;
  pmp_acc_e  req_type;
  priv_lvl_e req_priv;

  // Response side, one cycle after the request
  logic      rsp_valid;
  logic      rsp_err;
  pmp_addr_t rsp_addr;
  pmp_acc_e  rsp_type;

  // Access checker view
  modport check (
    input  req_valid, req_addr, req_type, req_priv,
    output rsp_valid, rsp_err, rsp_addr, rsp_type
  );

  // Fault logger only watches responses
  modport log (
    input rsp_valid, rsp_err, rsp_addr, rsp_type
  );

endinterface

`default_nettype wire

/* hw/pmp_csr_file.sv */
/* PMP CSR file
   Region cfg, address and mseccfg registers with lock rules and read-back */
`timescale 1ns/1ps
`include "pmp_config.svh"
`default_nettype none

module pmp_csr_file (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           csr_we_i,
  input  pmp_pkg::csr_sel_e              csr_sel_i,
  input  logic [`PMP_REGION_IDX_W-1:0]   csr_idx_i,
  input  logic [33:0]                    csr_wdata_i,
  output logic [33:0]                    csr_rdata_o,
  output pmp_pkg::pmp_cfg_t              cfg_o [`PMP_NUM_REGIONS],
  output pmp_pkg::pmp_addr_t             addr_o [`PMP_NUM_REGIONS],
  output pmp_pkg::pmp_mseccfg_t          mseccfg_o
);
  import pmp_pkg::*;

  // Register state
  pmp_cfg_t                    cfg_q [`PMP_NUM_REGIONS];
  pmp_addr_t                   addr_q [`PMP_NUM_REGIONS];
  pmp_mseccfg_t                mseccfg_q;

  // Write qualification
  logic [`PMP_NUM_REGIONS-1:0] addr_locked;
  logic                        idx_valid;
  logic                        cfg_wr_ok;
  logic                        addr_wr_ok;
  logic                        msec_wr;

  // Unpack a cfg byte, reserved bits 6:5 dropped
  function automatic pmp_cfg_t cfg_from_byte(logic [7:0] b);
    pmp_cfg_t c;
    c.lock  = b[7];
    c.mode  = pmp_mode_e'(b[4:3]);
    c.exec  = b[2];
    c.write = b[1];
    c.read  = b[0];
    return c;
  endfunction

  // Pack back, reserved bits read as zero
  function automatic logic [7:0] cfg_to_byte(pmp_cfg_t c);
    return {c.lock, 2'b00, c.mode, c.exec, c.write, c.read};
  endfunction

  // ----------------------------------------
  // Lock decode
  // ----------------------------------------

  // Address i is frozen by its own lock or by a locked TOR entry i+1
  for (genvar r = 0; r < `PMP_NUM_REGIONS; r++) begin : g_lock
    if (r < `PMP_NUM_REGIONS - 1) begin : g_mid
      assign addr_locked[r] = cfg_q[r].lock |
                              (cfg_q[r+1].lock & (cfg_q[r+1].mode == PMP_MODE_TOR));
    end else begin : g_last
      assign addr_locked[r] = cfg_q[r].lock;
    end
  end

  // Non power-of-two region counts leave holes in the index space
  assign idx_valid = 32'(csr_idx_i) < `PMP_NUM_REGIONS;

  // RLB bypasses every lock
  assign cfg_wr_ok  = csr_we_i & (csr_sel_i == CSR_SEL_CFG) & idx_valid &
                      (~cfg_q[csr_idx_i].lock | mseccfg_q.rlb);
  assign addr_wr_ok = csr_we_i & (csr_sel_i == CSR_SEL_ADDR) & idx_valid &
                      (~addr_locked[csr_idx_i] | mseccfg_q.rlb);
  assign msec_wr    = csr_we_i & (csr_sel_i == CSR_SEL_MSECCFG);

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // All regions OFF and unlocked
      for (int r = 0; r < `PMP_NUM_REGIONS; r++) begin
        cfg_q[r]  <= '0;
        addr_q[r] <= '0;
      end
      mseccfg_q <= '0;
    end else begin
      if (cfg_wr_ok) begin
        cfg_q[csr_idx_i] <= cfg_from_byte(csr_wdata_i[7:0]);
      end
      if (addr_wr_ok) begin
        addr_q[csr_idx_i] <= csr_wdata_i;
      end
      if (msec_wr) begin
        // MML and MMWP are sticky, only reset clears them
        mseccfg_q.mml  <= mseccfg_q.mml  | csr_wdata_i[0];
        mseccfg_q.mmwp <= mseccfg_q.mmwp | csr_wdata_i[1];
        mseccfg_q.rlb  <= csr_wdata_i[2];
      end
    end
  end

  // ----------------------------------------
  // Read-back
  // ----------------------------------------

  always_comb begin
    csr_rdata_o = '0;
    case (csr_sel_i)
      CSR_SEL_CFG: begin
        if (idx_valid) csr_rdata_o = {26'd0, cfg_to_byte(cfg_q[csr_idx_i])};
      end
      CSR_SEL_ADDR: begin
        if (idx_valid) csr_rdata_o = addr_q[csr_idx_i];
      end
      CSR_SEL_MSECCFG: csr_rdata_o = {31'd0, mseccfg_q.rlb, mseccfg_q.mmwp, mseccfg_q.mml};
      default:         csr_rdata_o = '0;
    endcase
  end

  // Live configuration to every checker
  assign cfg_o     = cfg_q;
  assign addr_o    = addr_q;
  assign mseccfg_o = mseccfg_q;

endmodule

`default_nettype wire

/* hw/pmp_access_check.sv */
/* PMP access checker for one channel
   Region match, basic and MML permission check, registered verdict */
`timescale 1ns/1ps
`include "pmp_config.svh"
`default_nettype none

module pmp_access_check (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  pmp_pkg::pmp_cfg_t      cfg_i [`PMP_NUM_REGIONS],
  input  pmp_pkg::pmp_addr_t     addr_i [`PMP_NUM_REGIONS],
  input  pmp_pkg::pmp_mseccfg_t  mseccfg_i,
  pmp_chan_if.check              chan
);
  import priv_pkg::*;
  import pmp_pkg::*;

  // Request fields
  pmp_addr_t                   req_addr;
  pmp_acc_e                    req_type;
  logic                        is_m;

  // Per-region decode
  pmp_addr_t                   region_start [`PMP_NUM_REGIONS];
  logic [33:`PMP_GRAN_LSB]     region_mask  [`PMP_NUM_REGIONS];
  logic [`PMP_NUM_REGIONS-1:0] na_hit;
  logic [`PMP_NUM_REGIONS-1:0] tor_hit;
  logic [`PMP_NUM_REGIONS-1:0] region_match;
  logic                        access_fault;

  // Plain R/W/X lookup
  function automatic logic basic_perm(pmp_cfg_t c, pmp_acc_e acc);
    case (acc)
      PMP_ACC_EXEC:  return c.exec;
      PMP_ACC_WRITE: return c.write;
      PMP_ACC_READ:  return c.read;
      default:       return 1'b0;
    endcase
  endfunction

  // Permission when mseccfg.MML is set
  function automatic logic mml_perm(pmp_cfg_t c, pmp_acc_e acc, logic m_mode);
    logic rd;
    logic wr;
    logic ex;
    rd = (acc == PMP_ACC_READ);
    wr = (acc == PMP_ACC_WRITE);
    ex = (acc == PMP_ACC_EXEC);
    if (!c.read && c.write) begin
      // Shared encodings, meaning picked by L and X
      case ({c.lock, c.exec})
        2'b00:   return rd | (wr & m_mode);
        2'b01:   return rd | wr;
        2'b10:   return ex;
        default: return ex | (rd & m_mode);
      endcase
    end else if (c.read && c.write && c.exec && c.lock) begin
      // Shared read-only for every mode
      return rd;
    end
    // Locked rules belong to M, unlocked to S/U
    return basic_perm(c, acc) & (m_mode ? c.lock : ~c.lock);
  endfunction

  assign req_addr = chan.req_addr;
  assign req_type = chan.req_type;
  assign is_m     = (chan.req_priv == PRIV_LVL_M);

  // ----------------------------------------
  // Region address decode
  // ----------------------------------------

  for (genvar r = 0; r < `PMP_NUM_REGIONS; r++) begin : g_region
    // TOR bottom is the previous entry, zero for entry 0
    if (r == 0) begin : g_first
      assign region_start[r] = (cfg_i[r].mode == PMP_MODE_TOR) ? '0 : addr_i[r];
    end else begin : g_rest
      assign region_start[r] = (cfg_i[r].mode == PMP_MODE_TOR) ? addr_i[r-1] : addr_i[r];
    end

    // NAPOT size from the trailing ones, each set bit opens one more mask bit
    always_comb begin : p_mask
      logic ones;
      ones = 1'b1;
      for (int b = `PMP_GRAN_LSB; b < 34; b++) begin
        if (b > 2) ones = ones & addr_i[r][b-1];
        region_mask[r][b] = (cfg_i[r].mode != PMP_MODE_NAPOT) | ~ones;
      end
    end

    // Compare only above the granule
    assign na_hit[r]  = ((req_addr[33:`PMP_GRAN_LSB] ^ region_start[r][33:`PMP_GRAN_LSB]) &
                         region_mask[r]) == '0;
    assign tor_hit[r] = (req_addr[33:`PMP_GRAN_LSB] >= region_start[r][33:`PMP_GRAN_LSB]) &
                        (req_addr[33:`PMP_GRAN_LSB] <  addr_i[r][33:`PMP_GRAN_LSB]);

    always_comb begin
      case (cfg_i[r].mode)
        PMP_MODE_TOR:   region_match[r] = tor_hit[r];
        PMP_MODE_NA4:   region_match[r] = na_hit[r];
        PMP_MODE_NAPOT: region_match[r] = na_hit[r];
        default:        region_match[r] = 1'b0;
      endcase
    end
  end

  // ----------------------------------------
  // Verdict
  // ----------------------------------------

  // Lowest matching entry wins, no match falls back to the default policy
  always_comb begin : p_verdict
    logic hit;
    hit          = 1'b0;
    access_fault = mseccfg_i.mmwp | ~is_m;
    for (int r = 0; r < `PMP_NUM_REGIONS; r++) begin
      if (!hit && region_match[r]) begin
        hit = 1'b1;
        if (mseccfg_i.mml) begin
          access_fault = ~mml_perm(cfg_i[r], req_type, is_m);
        end else if (is_m) begin
          // M mode only obeys locked entries
          access_fault = cfg_i[r].lock & ~basic_perm(cfg_i[r], req_type);
        end else begin
          access_fault = ~basic_perm(cfg_i[r], req_type);
        end
      end
    end
  end

  // Response one cycle after the request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      chan.rsp_valid <= 1'b0;
      chan.rsp_err   <= 1'b0;
    end else begin
      chan.rsp_valid <= chan.req_valid;
      chan.rsp_err   <= chan.req_valid & access_fault;
    end
  end

  // Address and type ride along with the verdict
  always_ff @(posedge clk_i) begin
    if (chan.req_valid) begin
      chan.rsp_addr <= req_addr;
      chan.rsp_type <= req_type;
    end
  end

endmodule

`default_nettype wire

/* hw/pmp_fault_log.sv */
/* PMP fault logger
   Captures the first faulting access of all channels until cleared */
`timescale 1ns/1ps
`include "pmp_config.svh"
`default_nettype none

module pmp_fault_log (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        fault_clear_i,
  pmp_chan_if.log                     chans [`PMP_NUM_CHAN],
  output logic                        fault_pending_o,
  output logic [`PMP_CHAN_IDX_W-1:0]  fault_chan_o,
  output pmp_pkg::pmp_addr_t          fault_addr_o,
  output priv_pkg::pmp_acc_e          fault_type_o
);
  import priv_pkg::*;
  import pmp_pkg::*;

  // Flattened channel responses
  logic [`PMP_NUM_CHAN-1:0]    chan_err;
  pmp_addr_t                   chan_addr [`PMP_NUM_CHAN];
  pmp_acc_e                    chan_type [`PMP_NUM_CHAN];

  // Priority select
  logic [`PMP_CHAN_IDX_W-1:0]  first_idx;
  logic                        capture;

  // ----------------------------------------
  // Gather responses
  // ----------------------------------------

  for (genvar c = 0; c < `PMP_NUM_CHAN; c++) begin : g_gather
    assign chan_err[c]  = chans[c].rsp_valid & chans[c].rsp_err;
    assign chan_addr[c] = chans[c].rsp_addr;
    assign chan_type[c] = chans[c].rsp_type;
  end

  // Fixed priority, channel 0 highest
  always_comb begin
    first_idx = '0;
    for (int c = `PMP_NUM_CHAN - 1; c >= 0; c--) begin
      if (chan_err[c]) first_idx = c[`PMP_CHAN_IDX_W-1:0];
    end
  end

  // A clear in the same cycle frees the slot for the new fault
  assign capture = (|chan_err) & (~fault_pending_o | fault_clear_i);

  // ----------------------------------------
  // Fault record
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fault_pending_o <= 1'b0;
    end else if (capture) begin
      fault_pending_o <= 1'b1;
    end else if (fault_clear_i) begin
      fault_pending_o <= 1'b0;
    end
  end

  // Record is frozen while pending
  always_ff @(posedge clk_i) begin
    if (capture) begin
      fault_chan_o <= first_idx;
      fault_addr_o <= chan_addr[first_idx];
      fault_type_o <= chan_type[first_idx];
    end
  end

endmodule

`default_nettype wire

/* hw/pmp_unit.sv */
/* PMP unit top level
   CSR file, per-channel access checkers and shared fault log */
`timescale 1ns/1ps
`include "pmp_config.svh"
`default_nettype none

module pmp_unit (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // CSR access
  input  logic                          csr_we_i,
  input  pmp_pkg::csr_sel_e             csr_sel_i,
  input  logic [`PMP_REGION_IDX_W-1:0]  csr_idx_i,
  input  logic [33:0]                   csr_wdata_i,
  output logic [33:0]                   csr_rdata_o,
  // Requests, one entry per channel
  input  logic [`PMP_NUM_CHAN-1:0]      req_valid_i,
  input  pmp_pkg::pmp_addr_t            req_addr_i [`PMP_NUM_CHAN],
  input  priv_pkg::pmp_acc_e            req_type_i [`PMP_NUM_CHAN],
  input  priv_pkg::priv_lvl_e           req_priv_i [`PMP_NUM_CHAN],
  // Responses
  output logic [`PMP_NUM_CHAN-1:0]      rsp_valid_o,
  output logic [`PMP_NUM_CHAN-1:0]      rsp_err_o,
  // Fault log
  input  logic                          fault_clear_i,
  output logic                          fault_pending_o,
  output logic [`PMP_CHAN_IDX_W-1:0]    fault_chan_o,
  output pmp_pkg::pmp_addr_t            fault_addr_o,
  output priv_pkg::pmp_acc_e            fault_type_o
);
  import pmp_pkg::*;

  // Configuration fanned out to all checkers
  pmp_cfg_t     cfg [`PMP_NUM_REGIONS];
  pmp_addr_t    addr [`PMP_NUM_REGIONS];
  pmp_mseccfg_t mseccfg;

  pmp_chan_if chan_if [`PMP_NUM_CHAN] ();

  pmp_csr_file u_csr_file (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_idx_i   (csr_idx_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .cfg_o       (cfg),
    .addr_o      (addr),
    .mseccfg_o   (mseccfg)
  );

  // ----------------------------------------
  // Checker array
  // ----------------------------------------

  for (genvar c = 0; c < `PMP_NUM_CHAN; c++) begin : g_chan
    assign chan_if[c].req_valid = req_valid_i[c];
    assign chan_if[c].req_addr  = req_addr_i[c];
    assign chan_if[c].req_type  = req_type_i[c];
    assign chan_if[c].req_priv  = req_priv_i[c];

    assign rsp_valid_o[c] = chan_if[c].rsp_valid;
    assign rsp_err_o[c]   = chan_if[c].rsp_err;

    pmp_access_check u_check (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .cfg_i     (cfg),
      .addr_i    (addr),
      .mseccfg_i (mseccfg),
      .chan      (chan_if[c])
    );
  end

  pmp_fault_log u_fault_log (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fault_clear_i   (fault_clear_i),
    .chans           (chan_if),
    .fault_pending_o (fault_pending_o),
    .fault_chan_o    (fault_chan_o),
    .fault_addr_o    (fault_addr_o),
    .fault_type_o    (fault_type_o)
  );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
/* Testbench clock and reset
   10 ns clock, synchronous reset held for the first 8 cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset drops on a rising edge, like any other driven input
  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

/* sim/tb_pmp_unit.sv */
/* PMP unit testbench
   LFSR stimulus, shadow CSR and verdict model, assertion based checking */
`timescale 1ns/1ps
`include "pmp_config.svh"
`default_nettype none

module tb_pmp_unit;
  import priv_pkg::*;
  import pmp_pkg::*;

  localparam int NR = `PMP_NUM_REGIONS;
  localparam int NC = `PMP_NUM_CHAN;
  localparam int GL = `PMP_GRAN_LSB;

  logic clk;
  logic reset;

  // DUT ports
  logic                         csr_we_i;
  csr_sel_e                     csr_sel_i;
  logic [`PMP_REGION_IDX_W-1:0] csr_idx_i;
  logic [33:0]                  csr_wdata_i;
  logic [33:0]                  csr_rdata_o;
  logic [NC-1:0]                req_valid_i;
  pmp_addr_t                    req_addr_i [NC];
  pmp_acc_e                     req_type_i [NC];
  priv_lvl_e                    req_priv_i [NC];
  logic [NC-1:0]                rsp_valid_o;
  logic [NC-1:0]                rsp_err_o;
  logic                         fault_clear_i;
  logic                         fault_pending_o;
  logic [`PMP_CHAN_IDX_W-1:0]   fault_chan_o;
  pmp_addr_t                    fault_addr_o;
  pmp_acc_e                     fault_type_o;

  // Shadow CSR state, cfg kept as the byte read back
  logic [7:0]  m_cfg [NR];
  logic [33:0] m_addr [NR];
  logic [2:0]  m_msec;
  logic [33:0] exp_rdata;

  // Model pipeline and fault record
  logic [NC-1:0] exp_err_q;
  logic [33:0]   exp_addr_q [NC];
  logic [1:0]    exp_type_q [NC];
  logic          log_pend;
  int            log_chan;
  logic [33:0]   log_addr;
  logic [1:0]    log_type;

  logic [31:0]   lfsr_q;

  tb_clk_gen u_clk_gen (.clk_o(clk), .reset_o(reset));

  pmp_unit u_dut (
    .clk_i(clk), .reset_i(reset),
    .csr_we_i(csr_we_i), .csr_sel_i(csr_sel_i), .csr_idx_i(csr_idx_i),
    .csr_wdata_i(csr_wdata_i), .csr_rdata_o(csr_rdata_o),
    .req_valid_i(req_valid_i), .req_addr_i(req_addr_i),
    .req_type_i(req_type_i), .req_priv_i(req_priv_i),
    .rsp_valid_o(rsp_valid_o), .rsp_err_o(rsp_err_o),
    .fault_clear_i(fault_clear_i), .fault_pending_o(fault_pending_o),
    .fault_chan_o(fault_chan_o), .fault_addr_o(fault_addr_o), .fault_type_o(fault_type_o)
  );

  task automatic stop_on_error(string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // ----------------------------------------
  // Random bits
  // ----------------------------------------

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic logic region_hit(int r, logic [33:0] a);
    logic [33:0] lo;
    int          k;
    lo = '0;
    k  = 0;
    case (m_cfg[r][4:3])
      2'b01: begin
        if (r > 0) lo = m_addr[r-1];
        return ((a >> GL) >= (lo >> GL)) && ((a >> GL) < (m_addr[r] >> GL));
      end
      2'b10: return (a >> GL) == (m_addr[r] >> GL);
      2'b11: begin
        // Trailing ones above bit 1 give the size
        while (k < 31 && m_addr[r][k+2]) k++;
        if (k + 3 < GL) k = GL - 3;
        return (a >> (k + 3)) == (m_addr[r] >> (k + 3));
      end
      default: return 1'b0;
    endcase
  endfunction

  // Smepmp truth table, t is 0 exec, 1 write, 2 read
  function automatic logic mml_allows(logic [7:0] c, logic [1:0] t, logic m);
    logic rd;
    logic wr;
    logic ex;
    rd = (t == 2'd2);
    wr = (t == 2'd1);
    ex = (t == 2'd0);
    if (c[1:0] == 2'b10) begin
      case ({c[7], c[2]})
        2'b00:   return rd | (m & wr);
        2'b01:   return rd | wr;
        2'b10:   return ex;
        default: return ex | (m & rd);
      endcase
    end
    if (c[7] && c[2:0] == 3'b111) return rd;
    if (m != c[7]) return 1'b0;
    return (ex & c[2]) | (wr & c[1]) | (rd & c[0]);
  endfunction

  function automatic logic model_fault(logic [33:0] a, logic [1:0] t, logic [1:0] p);
    logic m_mode;
    logic hit;
    logic fault;
    logic perm;
    m_mode = (p == 2'b11);
    fault  = m_msec[1] | ~m_mode;
    hit    = 1'b0;
    for (int r = 0; r < NR; r++) begin
      if (!hit && region_hit(r, a)) begin
        hit  = 1'b1;
        perm = (t == 2'd2) ? m_cfg[r][0] : (t == 2'd1) ? m_cfg[r][1] : m_cfg[r][2];
        if (m_msec[0]) fault = ~mml_allows(m_cfg[r], t, m_mode);
        else if (m_mode) fault = m_cfg[r][7] & ~perm;
        else fault = ~perm;
      end
    end
    return fault;
  endfunction

  // Expected verdicts and the first-fault record
  always @(posedge clk) begin : p_model
    logic cap;
    int   first;
    cap   = (|exp_err_q) & (~log_pend | fault_clear_i);
    first = 0;
    for (int c = NC - 1; c >= 0; c--) if (exp_err_q[c]) first = c;
    for (int c = 0; c < NC; c++) begin
      exp_err_q[c]  <= ~reset & req_valid_i[c] &
                       model_fault(req_addr_i[c], req_type_i[c], req_priv_i[c]);
      exp_addr_q[c] <= req_addr_i[c];
      exp_type_q[c] <= req_type_i[c];
    end
    if (reset) begin
      log_pend <= 1'b0;
    end else if (cap) begin
      log_pend <= 1'b1;
      log_chan <= first;
      log_addr <= exp_addr_q[first];
      log_type <= exp_type_q[first];
    end else if (fault_clear_i) begin
      log_pend <= 1'b0;
    end
  end

  always_comb begin
    exp_rdata = '0;
    if (csr_sel_i == CSR_SEL_CFG) exp_rdata = {26'd0, m_cfg[csr_idx_i]};
    else if (csr_sel_i == CSR_SEL_ADDR) exp_rdata = m_addr[csr_idx_i];
    else if (csr_sel_i == CSR_SEL_MSECCFG) exp_rdata = {31'd0, m_msec};
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  for (genvar c = 0; c < NC; c++) begin : g_rsp_chk
    a_rsp: assert property (@(posedge clk) disable iff (reset)
      req_valid_i[c] |=> rsp_valid_o[c] && (rsp_err_o[c] == exp_err_q[c]))
      else stop_on_error($sformatf("Fail rsp_err_o[%0d]: got %h, expected %h",
                                   c, rsp_err_o[c], exp_err_q[c]));
    a_idle: assert property (@(posedge clk) disable iff (reset)
      !req_valid_i[c] |=> !rsp_valid_o[c])
      else stop_on_error($sformatf("Fail rsp_valid_o[%0d]: got %h, expected 0",
                                   c, rsp_valid_o[c]));
  end

  a_rdata: assert property (@(posedge clk) disable iff (reset) csr_rdata_o == exp_rdata)
    else stop_on_error($sformatf("Fail csr_rdata_o: got %h, expected %h",
                                 csr_rdata_o, exp_rdata));

  a_pend: assert property (@(posedge clk) disable iff (reset) fault_pending_o == log_pend)
    else stop_on_error($sformatf("Fail fault_pending_o: got %h, expected %h",
                                 fault_pending_o, log_pend));

  a_rec: assert property (@(posedge clk) disable iff (reset) log_pend |->
    (32'(fault_chan_o) == log_chan) && (fault_addr_o == log_addr) && (fault_type_o == log_type))
    else stop_on_error($sformatf("Fail fault record: got %h/%h/%h, expected %h/%h/%h",
                                 fault_chan_o, fault_addr_o, fault_type_o,
                                 log_chan, log_addr, log_type));

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------

  task automatic csr_write(csr_sel_e sel, int idx, logic [33:0] d);
    @(posedge clk);
    csr_we_i    <= 1'b1;
    csr_sel_i   <= sel;
    csr_idx_i   <= idx[`PMP_REGION_IDX_W-1:0];
    csr_wdata_i <= d;
    @(posedge clk);
    csr_we_i <= 1'b0;
    // Shadow follows the lock, TOR lock, RLB and sticky rules
    if (sel == CSR_SEL_CFG && (!m_cfg[idx][7] || m_msec[2])) begin
      m_cfg[idx] <= {d[7], 2'b00, d[4:0]};
    end
    if (sel == CSR_SEL_ADDR && (m_msec[2] || !(m_cfg[idx][7] ||
        (idx < NR - 1 && m_cfg[idx+1][7] && m_cfg[idx+1][4:3] == 2'b01)))) begin
      m_addr[idx] <= d;
    end
    if (sel == CSR_SEL_MSECCFG) m_msec <= {d[2], m_msec[1:0] | d[1:0]};
  endtask

  task automatic drive_req(int ch, logic v, logic [33:0] a, logic [1:0] t, logic [1:0] p);
    req_valid_i[ch] <= v;
    req_addr_i[ch]  <= a;
    req_type_i[ch]  <= pmp_acc_e'(t);
    req_priv_i[ch]  <= priv_lvl_e'(p);
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      for (int c = 0; c < NC; c++) drive_req(c, 1'b0, '0, 2'd2, 2'b11);
    end
  endtask

  // Back-to-back random traffic on every channel
  task automatic random_burst(int n);
    logic [31:0] t;
    logic [31:0] p;
    logic [31:0] v;
    logic [31:0] a;
    repeat (n) begin
      @(posedge clk);
      for (int c = 0; c < NC; c++) begin
        t = rand_bits(2);
        p = rand_bits(2);
        v = rand_bits(2);
        a = rand_bits(12);
        if (t[1:0] == 2'd3) t[1:0] = 2'd2;
        if (p[1:0] == 2'b10) p[1:0] = 2'b11;
        drive_req(c, v[1:0] != 2'd0, {20'd0, a[11:0], 2'b00}, t[1:0], p[1:0]);
      end
    end
    idle(2);
  endtask

  // Every type and privilege at one address
  task automatic probe(logic [33:0] a);
    for (int t = 0; t < 3; t++) begin
      for (int p = 0; p < 4; p++) begin
        if (p != 2) begin
          @(posedge clk);
          drive_req(0, 1'b1, a, t[1:0], p[1:0]);
          drive_req(1, 1'b1, a, t[1:0], (p == 3) ? 2'b00 : 2'b11);
        end
      end
    end
    idle(2);
  endtask

  task automatic wait_pending(logic lvl);
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (fault_pending_o == lvl) return;
    end
    stop_on_error("Timeout while waiting for the fault log to change state");
  endtask

  task automatic clear_log();
    @(posedge clk);
    fault_clear_i <= 1'b1;
    @(posedge clk);
    fault_clear_i <= 1'b0;
    wait_pending(1'b0);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    lfsr_q        = 32'hefef_d612;
    csr_we_i      = 1'b0;
    csr_sel_i     = CSR_SEL_CFG;
    csr_idx_i     = '0;
    csr_wdata_i   = '0;
    fault_clear_i = 1'b0;
    m_msec        = '0;
    for (int r = 0; r < NR; r++) begin
      m_cfg[r]  = '0;
      m_addr[r] = '0;
    end
    for (int c = 0; c < NC; c++) drive_req(c, 1'b0, '0, 2'd2, 2'b11);

    for (int i = 0; i < 50 && reset; i++) @(negedge clk);
    if (reset) stop_on_error("Reset was never released");
    @(negedge clk);
    assert (rsp_valid_o == '0)
      else stop_on_error($sformatf("Fail rsp_valid_o: got %h, expected 0", rsp_valid_o));
    assert (!fault_pending_o)
      else stop_on_error($sformatf("Fail fault_pending_o: got %h, expected 0",
                                   fault_pending_o));
    random_burst(30);
    clear_log();

    // TOR, NA4 and NAPOT regions with boundaries
    csr_write(CSR_SEL_ADDR, 0, 34'h100);
    csr_write(CSR_SEL_CFG, 0, 34'h09);
    csr_write(CSR_SEL_ADDR, 1, 34'h200);
    csr_write(CSR_SEL_CFG, 1, 34'h13);
    csr_write(CSR_SEL_ADDR, 2, 34'h17fc);
    csr_write(CSR_SEL_CFG, 2, 34'h1d);
    csr_write(CSR_SEL_ADDR, 3, 34'h2000);
    csr_write(CSR_SEL_CFG, 3, 34'h0a);
    probe(34'h0fc);
    probe(34'h100);
    probe(34'h200);
    probe(34'h204);
    probe(34'h1000);
    probe(34'h1ffc);
    probe(34'h2000);
    random_burst(200);

    // Overlap with a locked execute-only entry in front
    csr_write(CSR_SEL_ADDR, 0, 34'h1000);
    csr_write(CSR_SEL_CFG, 0, 34'h94);
    csr_write(CSR_SEL_CFG, 1, 34'h91);
    probe(34'h1000);
    probe(34'h1004);
    probe(34'h200);
    random_burst(100);

    // Locked entries ignore writes until RLB is set
    csr_write(CSR_SEL_CFG, 0, 34'h00);
    csr_write(CSR_SEL_ADDR, 0, 34'h3000);
    csr_write(CSR_SEL_CFG, 3, 34'h8a);
    csr_write(CSR_SEL_ADDR, 2, 34'h27fc);
    csr_write(CSR_SEL_MSECCFG, 0, 34'h4);
    csr_write(CSR_SEL_CFG, 0, 34'h00);
    csr_write(CSR_SEL_ADDR, 0, 34'h3000);
    csr_write(CSR_SEL_ADDR, 2, 34'h27fc);
    csr_write(CSR_SEL_CFG, 3, 34'h0a);
    csr_write(CSR_SEL_MSECCFG, 0, 34'h0);
    random_burst(50);

    // Fault log priority, hold and clear
    clear_log();
    @(posedge clk);
    drive_req(0, 1'b1, 34'h3f00, 2'd2, 2'b00);
    drive_req(1, 1'b1, 34'h3f04, 2'd1, 2'b00);
    idle(1);
    wait_pending(1'b1);
    assert (fault_chan_o == '0)
      else stop_on_error($sformatf("Fail fault_chan_o: got %h, expected 0", fault_chan_o));
    @(posedge clk);
    drive_req(1, 1'b1, 34'h3f08, 2'd0, 2'b01);
    idle(4);
    @(negedge clk);
    assert (fault_addr_o == 34'h3f00)
      else stop_on_error($sformatf("Fail fault_addr_o: got %h, expected %h",
                                   fault_addr_o, 34'h3f00));
    clear_log();

    // MML encodings, then MMWP, both sticky
    csr_write(CSR_SEL_MSECCFG, 0, 34'h5);
    csr_write(CSR_SEL_ADDR, 0, 34'h1000);
    csr_write(CSR_SEL_CFG, 0, 34'h12);
    csr_write(CSR_SEL_CFG, 1, 34'h96);
    csr_write(CSR_SEL_CFG, 2, 34'h9f);
    csr_write(CSR_SEL_ADDR, 3, 34'h3400);
    csr_write(CSR_SEL_CFG, 3, 34'h09);
    csr_write(CSR_SEL_MSECCFG, 0, 34'h0);
    probe(34'h1000);
    probe(34'h200);
    probe(34'h2800);
    probe(34'h3000);
    probe(34'h3800);
    // Same range locked, now a rule for M only
    csr_write(CSR_SEL_CFG, 3, 34'h89);
    probe(34'h3000);
    random_burst(150);
    csr_write(CSR_SEL_MSECCFG, 0, 34'h2);
    csr_write(CSR_SEL_MSECCFG, 0, 34'h0);
    probe(34'h3800);
    random_burst(150);
    idle(4);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
hw/priv_pkg.sv
hw/pmp_pkg.sv
hw/pmp_chan_if.sv
hw/pmp_csr_file.sv
hw/pmp_access_check.sv
hw/pmp_fault_log.sv
hw/pmp_unit.sv
sim/tb_clk_gen.sv
sim/tb_pmp_unit.sv

/* Makefile */
SRCS := $(wildcard hw/*.sv sim/*.sv include/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_pmp_unit: src.f $(SRCS)
	verilator --binary --timing --assert -f src.f --top-module tb_pmp_unit -o Vtb_pmp_unit

sim.log: obj_dir/Vtb_pmp_unit
	-./obj_dir/Vtb_pmp_unit > sim.log 2>&1

run: obj_dir/Vtb_pmp_unit
	-./obj_dir/Vtb_pmp_unit > sim.log 2>&1
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
